/* source/calc_pkg.sv */
// Calculator shared types
package calc_pkg;

    // Operand and result width unless the top level overrides it
    parameter int DATA_WIDTH_DEFAULT = 16;

    // One decimal key, 0 to 9
    typedef logic [3:0] digit_t;

    // Operator keys
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_MUL  = 2'd2,
        OP_NONE = 2'd3
    } op_t;

    // Entry controller states
    typedef enum logic [3:0] {
        IDLE_OP1    = 4'd0,
        SCALE_OP1   = 4'd1,
        ADD_DIGIT1  = 4'd2,
        IDLE_OP2    = 4'd3,
        SCALE_OP2   = 4'd4,
        ADD_DIGIT2  = 4'd5,
        DISPATCH    = 4'd6,
        WAIT_RESULT = 4'd7,
        SHOW        = 4'd8
    } ctrl_state_t;

endpackage

/* source/add_sub_unit.sv */
// Registered adder and subtractor
`timescale 1ns/1ps

module add_sub_unit #(
    parameter int DATA_WIDTH = calc_pkg::DATA_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  logic                  sub,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  finish
);

    typedef logic [DATA_WIDTH-1:0] word_t;

    word_t sum;
    word_t diff;

    // Both wrap modulo 2^DATA_WIDTH
    assign sum  = a + b;
    assign diff = a - b;

    // Result holds until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            result <= sub ? diff : sum;
        end
    end

    // One cycle of latency
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

endmodule

/* source/shift_add_multiplier.sv */
// Sequential shift and add multiplier
`timescale 1ns/1ps

module shift_add_multiplier #(
    parameter int DATA_WIDTH = calc_pkg::DATA_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    output logic [DATA_WIDTH-1:0] product,
    output logic                  busy,
    output logic                  finish
);

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [CNT_W-1:0] count_t;

    word_t  mcand;
    word_t  mplier;
    word_t  acc;
    count_t step;
    logic   last_step;

    assign last_step = (step == count_t'(DATA_WIDTH - 1));

    // Step counter and handshake
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            finish <= 1'b0;
            step   <= '0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + count_t'(1);
                if (last_step) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // Upper bits fall off, which gives the modulo result
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Low half of the product, held after finish
    assign product = acc;

endmodule

/* source/entry_controller.sv */
// Keypad entry and dispatch controller
`timescale 1ns/1ps

module entry_controller #(
    parameter int DATA_WIDTH = calc_pkg::DATA_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  key_valid,
    input  calc_pkg::digit_t      key_digit,
    input  logic                  op_valid,
    input  calc_pkg::op_t         op_code,
    input  logic                  equal_valid,
    input  logic [DATA_WIDTH-1:0] mul_product,
    input  logic                  mul_finish,
    input  logic [DATA_WIDTH-1:0] as_result,
    input  logic                  as_finish,
    output logic                  ready,
    output logic                  complete,
    output logic [DATA_WIDTH-1:0] display,
    output logic                  mul_start,
    output logic [DATA_WIDTH-1:0] mul_a,
    output logic [DATA_WIDTH-1:0] mul_b,
    output logic                  as_start,
    output logic [DATA_WIDTH-1:0] as_a,
    output logic [DATA_WIDTH-1:0] as_b,
    output logic                  as_sub
);

    typedef logic [DATA_WIDTH-1:0] word_t;

    localparam word_t TEN = word_t'(10);

    calc_pkg::ctrl_state_t state;
    calc_pkg::op_t         op_q;
    calc_pkg::digit_t      digit_q;

    word_t operand1;
    word_t operand2;
    word_t result_q;
    word_t entry_sum;
    logic  have_op1;
    logic  have_op2;
    logic  key_accept;
    logic  op_accept;
    logic  eq_accept;

    // Keys are only taken while waiting for input
    assign ready = (state == calc_pkg::IDLE_OP1) || (state == calc_pkg::IDLE_OP2);

    assign key_accept = key_valid && ready;
    assign op_accept  = op_valid && (state == calc_pkg::IDLE_OP1) && have_op1;
    assign eq_accept  = equal_valid && (state == calc_pkg::IDLE_OP2) && have_op2;

    // Scaled operand plus the latched digit
    assign entry_sum = mul_product + word_t'(digit_q);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= calc_pkg::IDLE_OP1;
            op_q      <= calc_pkg::OP_NONE;
            operand1  <= '0;
            operand2  <= '0;
            have_op1  <= 1'b0;
            have_op2  <= 1'b0;
            display   <= '0;
            complete  <= 1'b0;
            mul_start <= 1'b0;
            as_start  <= 1'b0;
        end else begin
            complete  <= 1'b0;
            mul_start <= 1'b0;
            as_start  <= 1'b0;
            case (state)
                calc_pkg::IDLE_OP1: begin
                    if (key_accept) begin
                        mul_start <= 1'b1;
                        have_op1  <= 1'b1;
                        state     <= calc_pkg::SCALE_OP1;
                    end else if (op_accept) begin
                        op_q  <= op_code;
                        state <= calc_pkg::IDLE_OP2;
                    end
                end
                calc_pkg::SCALE_OP1: begin
                    if (mul_finish) begin
                        state <= calc_pkg::ADD_DIGIT1;
                    end
                end
                calc_pkg::ADD_DIGIT1: begin
                    operand1 <= entry_sum;
                    display  <= entry_sum;
                    state    <= calc_pkg::IDLE_OP1;
                end
                calc_pkg::IDLE_OP2: begin
                    if (key_accept) begin
                        mul_start <= 1'b1;
                        have_op2  <= 1'b1;
                        state     <= calc_pkg::SCALE_OP2;
                    end else if (eq_accept) begin
                        state <= calc_pkg::DISPATCH;
                    end
                end
                calc_pkg::SCALE_OP2: begin
                    if (mul_finish) begin
                        state <= calc_pkg::ADD_DIGIT2;
                    end
                end
                calc_pkg::ADD_DIGIT2: begin
                    operand2 <= entry_sum;
                    display  <= entry_sum;
                    state    <= calc_pkg::IDLE_OP2;
                end
                calc_pkg::DISPATCH: begin
                    if (op_q == calc_pkg::OP_MUL) begin
                        mul_start <= 1'b1;
                    end else begin
                        as_start <= 1'b1;
                    end
                    state <= calc_pkg::WAIT_RESULT;
                end
                calc_pkg::WAIT_RESULT: begin
                    if (as_finish || mul_finish) begin
                        state <= calc_pkg::SHOW;
                    end
                end
                calc_pkg::SHOW: begin
                    display  <= result_q;
                    complete <= 1'b1;
                    operand1 <= '0;
                    operand2 <= '0;
                    have_op1 <= 1'b0;
                    have_op2 <= 1'b0;
                    op_q     <= calc_pkg::OP_NONE;
                    state    <= calc_pkg::IDLE_OP1;
                end
                default: state <= calc_pkg::IDLE_OP1;
            endcase
        end
    end

    // Operands for the arithmetic units, stable while start is high
    always_ff @(posedge clk) begin
        if (key_accept) begin
            digit_q <= key_digit;
            mul_a   <= (state == calc_pkg::IDLE_OP1) ? operand1 : operand2;
            mul_b   <= TEN;
        end else if (state == calc_pkg::DISPATCH) begin
            mul_a  <= operand1;
            mul_b  <= operand2;
            as_a   <= operand1;
            as_b   <= operand2;
            as_sub <= (op_q == calc_pkg::OP_SUB);
        end
        if (state == calc_pkg::WAIT_RESULT) begin
            if (as_finish) begin
                result_q <= as_result;
            end else if (mul_finish) begin
                result_q <= mul_product;
            end
        end
    end

endmodule

/* source/calculator_top.sv */
// Keypad calculator core
`timescale 1ns/1ps

module calculator_top #(
    parameter int DATA_WIDTH = calc_pkg::DATA_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  key_valid,
    input  calc_pkg::digit_t      key_digit,
    input  logic                  op_valid,
    input  calc_pkg::op_t         op_code,
    input  logic                  equal_valid,
    output logic                  ready,
    output logic                  complete,
    output logic [DATA_WIDTH-1:0] display
);

    logic                  mul_start;
    logic [DATA_WIDTH-1:0] mul_a;
    logic [DATA_WIDTH-1:0] mul_b;
    logic [DATA_WIDTH-1:0] mul_product;
    logic                  mul_finish;
    logic                  mul_busy;
    logic                  as_start;
    logic [DATA_WIDTH-1:0] as_a;
    logic [DATA_WIDTH-1:0] as_b;
    logic                  as_sub;
    logic [DATA_WIDTH-1:0] as_result;
    logic                  as_finish;

    entry_controller #(
        .DATA_WIDTH(DATA_WIDTH)
    ) ctrl0 (
        .clk         (clk),
        .nRST        (nRST),
        .key_valid   (key_valid),
        .key_digit   (key_digit),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .equal_valid (equal_valid),
        .mul_product (mul_product),
        .mul_finish  (mul_finish),
        .as_result   (as_result),
        .as_finish   (as_finish),
        .ready       (ready),
        .complete    (complete),
        .display     (display),
        .mul_start   (mul_start),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .as_start    (as_start),
        .as_a        (as_a),
        .as_b        (as_b),
        .as_sub      (as_sub)
    );

    add_sub_unit #(
        .DATA_WIDTH(DATA_WIDTH)
    ) addsub0 (
        .clk    (clk),
        .nRST   (nRST),
        .start  (as_start),
        .a      (as_a),
        .b      (as_b),
        .sub    (as_sub),
        .result (as_result),
        .finish (as_finish)
    );

    // Shared by digit scaling and the multiply operator
    shift_add_multiplier #(
        .DATA_WIDTH(DATA_WIDTH)
    ) mult0 (
        .clk     (clk),
        .nRST    (nRST),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .product (mul_product),
        .busy    (mul_busy),
        .finish  (mul_finish)
    );

endmodule

/* tests/calculator_chk.sv */
// Calculator protocol checks
`timescale 1ns/1ps

module calculator_chk #(
    parameter int DATA_WIDTH = calc_pkg::DATA_WIDTH_DEFAULT
) (
    input logic                  clk,
    input logic                  nRST,
    input logic                  ready,
    input logic                  complete,
    input logic [DATA_WIDTH-1:0] display,
    input logic                  mul_busy,
    input logic                  mul_start
);

    // Complete is a single cycle pulse
    complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else $error("complete stayed high for two cycles");

    busy_blocks_keys: assert property (@(posedge clk) disable iff (!nRST)
        mul_busy |-> !ready)
        else $error("ready was high while the multiplier was busy");

    display_known: assert property (@(posedge clk) disable iff (!nRST)
        !$isunknown(display))
        else $error("display has unknown bits");

    // No restart of a running multiply
    start_when_idle: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> !mul_busy)
        else $error("multiplier started while busy");

endmodule

bind calculator_top calculator_chk #(
    .DATA_WIDTH(DATA_WIDTH)
) chk0 (
    .clk       (clk),
    .nRST      (nRST),
    .ready     (ready),
    .complete  (complete),
    .display   (display),
    .mul_busy  (mul_busy),
    .mul_start (mul_start)
);

/* tests/calculator_tb.sv */
// Calculator core testbench
`timescale 1ns/1ps

module calculator_tb;

    localparam int W = 16;
    localparam int MOD = 1 << W;
    localparam int CYCLE_LIMIT = 20000;

    logic             clk;
    logic             nRST;
    logic             key_valid;
    calc_pkg::digit_t key_digit;
    logic             op_valid;
    calc_pkg::op_t    op_code;
    logic             equal_valid;
    logic             ready;
    logic             complete;
    logic [W-1:0]     display;

    logic [31:0] rng;
    int          model_entry;
    int          cycles;

    calculator_top #(
        .DATA_WIDTH(W)
    ) dut0 (
        .clk         (clk),
        .nRST        (nRST),
        .key_valid   (key_valid),
        .key_digit   (key_digit),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .equal_valid (equal_valid),
        .ready       (ready),
        .complete    (complete),
        .display     (display)
    );

    always #20 clk = ~clk;

    // Run limit, well above what the tests need
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the DUT stopped responding before the tests finished");
            $display("*** TEST FAILED ***");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Reference arithmetic, modulo 2^W
    function automatic int model_result(input int a, input calc_pkg::op_t op, input int b);
        case (op)
            calc_pkg::OP_ADD: return (a + b) % MOD;
            calc_pkg::OP_SUB: return (a - b + MOD) % MOD;
            default:          return (a * b) % MOD;
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_ready();
        while (!ready) @(negedge clk);
    endtask

    // Digit key pulse; stray adds a second key while the DUT is busy
    task automatic enter_digit(input int d, input bit stray, input string name);
        wait_ready();
        @(posedge clk);
        key_valid <= 1'b1;
        key_digit <= calc_pkg::digit_t'(d);
        @(posedge clk);
        key_valid <= 1'b0;
        if (stray) begin
            @(posedge clk);
            key_valid <= 1'b1;
            key_digit <= calc_pkg::digit_t'(9);
            @(posedge clk);
            key_valid <= 1'b0;
        end
        @(negedge clk);
        wait_ready();
        model_entry = (model_entry * 10 + d) % MOD;
        check_value(name, model_entry, int'(display));
    endtask

    task automatic enter_decimal(input int value, input string name);
        int digs[$];
        int v;
        v = value;
        do begin
            digs.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digs[i]) begin
            enter_digit(digs[i], 1'b0, name);
        end
    endtask

    task automatic send_op(input calc_pkg::op_t op);
        wait_ready();
        @(posedge clk);
        op_valid <= 1'b1;
        op_code  <= op;
        @(posedge clk);
        op_valid <= 1'b0;
        @(negedge clk);
        model_entry = 0;
    endtask

    task automatic pulse_equal();
        @(posedge clk);
        equal_valid <= 1'b1;
        @(posedge clk);
        equal_valid <= 1'b0;
    endtask

    task automatic press_equal(input string name, input int expected);
        wait_ready();
        pulse_equal();
        do @(negedge clk); while (!complete);
        check_value(name, expected, int'(display));
    endtask

    task automatic run_calc(input int a, input calc_pkg::op_t op, input int b,
                            input string name);
        int expected;
        expected = model_result(a, op, b);
        model_entry = 0;
        enter_decimal(a, name);
        send_op(op);
        enter_decimal(b, name);
        press_equal(name, expected);
    endtask

    initial begin
        int a;
        int b;
        clk         = 1'b0;
        nRST        = 1'b0;
        key_valid   = 1'b0;
        key_digit   = '0;
        op_valid    = 1'b0;
        op_code     = calc_pkg::OP_NONE;
        equal_valid = 1'b0;
        cycles      = 0;
        model_entry = 0;
        rng         = 32'hca1c;
        repeat (5) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);

        check_value("reset ready", 1, int'(ready));
        check_value("reset complete", 0, int'(complete));
        check_value("reset display", 0, int'(display));

        run_calc(427, calc_pkg::OP_SUB, 27, "entry 427");
        run_calc(123, calc_pkg::OP_ADD, 456, "add");
        run_calc(5, calc_pkg::OP_SUB, 12, "sub wrap");

        // Random products of 1 to 3 digit operands
        for (int i = 0; i < 20; i++) begin
            rng = xorshift(rng);
            a = int'(rng % 1000) % (10 ** (1 + int'(rng[15:8] % 3)));
            rng = xorshift(rng);
            b = int'(rng % 1000) % (10 ** (1 + int'(rng[15:8] % 3)));
            run_calc(a, calc_pkg::OP_MUL, b, $sformatf("mul %0d", i));
        end

        // Stray key while busy must be dropped
        model_entry = 0;
        enter_digit(3, 1'b0, "back-pressure");
        enter_digit(1, 1'b1, "back-pressure");
        send_op(calc_pkg::OP_ADD);
        enter_decimal(5, "back-pressure");
        press_equal("back-pressure", 36);

        // Equal before any operator
        model_entry = 0;
        enter_decimal(89, "early equal");
        pulse_equal();
        repeat (3) @(negedge clk);
        check_value("early equal ready", 1, int'(ready));
        check_value("early equal complete", 0, int'(complete));
        check_value("early equal display", 89, int'(display));
        send_op(calc_pkg::OP_MUL);
        enter_decimal(3, "early equal");
        press_equal("early equal", 267);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* all.f */
source/calc_pkg.sv
source/add_sub_unit.sv
source/shift_add_multiplier.sv
source/entry_controller.sv
source/calculator_top.sv
tests/calculator_chk.sv
tests/calculator_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module calculator_tb --Mdir obj_dir

./obj_dir/Vcalculator_tb | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
